//--- build.f
design/core_types_pkg.sv
design/btb_tag_hash.sv
design/bram_1rport_1wport.sv
design/bram_2rport_1wport.sv
design/btb.sv
design/btb_pred_select.sv
design/branch_pred_top.sv
verification/branch_pred_assert.sv
verification/branch_pred_tb.sv

//--- design/bram_1rport_1wport.sv
// ------------------------------------------------------------
// RAM with one registered read port and one write port masked
// per BTB entry; every row is cleared on reset
// ------------------------------------------------------------

`timescale 1ns/1ps

module bram_1rport_1wport #(
    parameter int INNER_WIDTH = core_types_pkg::BTB_ROW_WIDTH,
    parameter int OUTER_WIDTH = core_types_pkg::BTB_SETS
) (
    input  logic                           CLK,
    input  logic                           nRST,

    // read port
    input  logic                           ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] rindex,
    output logic [INNER_WIDTH-1:0]         rdata,

    // write port, one mask bit per entry
    input  logic [INNER_WIDTH/core_types_pkg::BTB_ENTRY_WIDTH-1:0] wen_mask,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            for (int r = 0; r < OUTER_WIDTH; r++) begin
                mem[r] <= '0;
            end
            rdata <= '0;
        end else begin
            // read sees the row as it was before this edge's write
            if (ren) begin
                rdata <= mem[rindex];
            end
            for (int e = 0; e < INNER_WIDTH / core_types_pkg::BTB_ENTRY_WIDTH; e++) begin
                if (wen_mask[e]) begin
                    mem[windex][e*core_types_pkg::BTB_ENTRY_WIDTH +: core_types_pkg::BTB_ENTRY_WIDTH]
                        <= wdata[e*core_types_pkg::BTB_ENTRY_WIDTH
                                 +: core_types_pkg::BTB_ENTRY_WIDTH];
                end
            end
        end
    end

endmodule

//--- design/bram_2rport_1wport.sv
// ------------------------------------------------------------
// RAM with two registered read ports and one bit-masked write
// port; holds the per-slot LRU bits of the BTB
// ------------------------------------------------------------

`timescale 1ns/1ps

module bram_2rport_1wport #(
    parameter int INNER_WIDTH = core_types_pkg::BTB_SLOTS,
    parameter int OUTER_WIDTH = core_types_pkg::BTB_SETS
) (
    input  logic                           CLK,
    input  logic                           nRST,

    // read port 0
    input  logic                           port0_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port0_rindex,
    output logic [INNER_WIDTH-1:0]         port0_rdata,

    // read port 1
    input  logic                           port1_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port1_rindex,
    output logic [INNER_WIDTH-1:0]         port1_rdata,

    // write port, one mask bit per data bit
    input  logic [INNER_WIDTH-1:0]         wen_mask,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            for (int r = 0; r < OUTER_WIDTH; r++) begin
                mem[r] <= '0;
            end
            port0_rdata <= '0;
            port1_rdata <= '0;
        end else begin
            if (port0_ren) begin
                port0_rdata <= mem[port0_rindex];
            end
            if (port1_ren) begin
                port1_rdata <= mem[port1_rindex];
            end

            // bitwise merge of the masked write
            for (int b = 0; b < INNER_WIDTH; b++) begin
                if (wen_mask[b]) begin
                    mem[windex][b] <= wdata[b];
                end
            end
        end
    end

endmodule

//--- design/branch_pred_top.sv
// ------------------------------------------------------------
// fetch-side branch prediction top: BTB lookup followed by
// next-address selection, one cycle from request to prediction
// ------------------------------------------------------------

`timescale 1ns/1ps

module branch_pred_top (
    input  logic                          CLK,
    input  logic                          nRST,

    input  logic                          valid_REQ,
    input  core_types_pkg::btb_req_t      req,

    input  logic                          update0_valid,
    input  core_types_pkg::btb_update0_t  update0,
    input  core_types_pkg::btb_update1_t  update1,

    output logic                          resp_valid,
    output core_types_pkg::btb_resp_t     resp,
    output core_types_pkg::btb_pred_t     pred
);

    btb btb_inst (
        .CLK           (CLK),
        .nRST          (nRST),
        .valid_REQ     (valid_REQ),
        .req           (req),
        .resp_valid    (resp_valid),
        .resp          (resp),
        .update0_valid (update0_valid),
        .update0       (update0),
        .update1       (update1)
    );

    btb_pred_select select_inst (
        .CLK       (CLK),
        .nRST      (nRST),
        .valid_REQ (valid_REQ),
        .req_pc    (req.pc),
        .resp      (resp),
        .pred      (pred)
    );

endmodule

//--- design/btb.sv
// ------------------------------------------------------------
// branch target buffer: looks up all sixteen slots of a fetch
// block and answers one cycle later; updates arrive as two
// strobes on consecutive cycles and write at the second one
// ------------------------------------------------------------

`timescale 1ns/1ps

module btb (
    input  logic                          CLK,
    input  logic                          nRST,

    // request
    input  logic                          valid_REQ,
    input  core_types_pkg::btb_req_t      req,

    // response, one cycle after the request
    output logic                          resp_valid,
    output core_types_pkg::btb_resp_t     resp,

    // update 0 then update 1 on the next cycle
    input  logic                          update0_valid,
    input  core_types_pkg::btb_update0_t  update0,
    input  core_types_pkg::btb_update1_t  update1
);

    // request stage
    logic [core_types_pkg::BTB_INDEX_WIDTH-1:0] req_index;
    logic [core_types_pkg::BTB_TAG_WIDTH-1:0]   req_tag;

    // response stage
    logic [core_types_pkg::BTB_TAG_WIDTH-1:0]   resp_tag;
    core_types_pkg::btb_entry_t [core_types_pkg::BTB_SLOTS-1:0][core_types_pkg::BTB_ASSOC-1:0]
        rd_entries;
    logic [core_types_pkg::BTB_SLOTS-1:0]       rd_lru;
    logic [core_types_pkg::BTB_SLOTS-1:0][core_types_pkg::BTB_ASSOC-1:0] way_match;

    // update 0 stage
    logic [core_types_pkg::BTB_INDEX_WIDTH-1:0] upd0_index;
    logic [core_types_pkg::BTB_SLOT_WIDTH-1:0]  upd0_slot;
    logic [core_types_pkg::BTB_TAG_WIDTH-1:0]   upd0_tag;

    // update 1 stage
    logic                                       upd1_valid;
    logic [core_types_pkg::BTB_INDEX_WIDTH-1:0] upd1_index;
    logic [core_types_pkg::BTB_SLOT_WIDTH-1:0]  upd1_slot;
    logic [core_types_pkg::BTB_TAG_WIDTH-1:0]   upd1_tag;
    logic [core_types_pkg::BTB_SLOTS-1:0]       upd1_old_lru;
    logic [core_types_pkg::BTB_SLOTS-1:0]       upd1_new_lru;
    core_types_pkg::btb_entry_t                 upd1_entry;
    logic [core_types_pkg::BTB_SLOTS-1:0][core_types_pkg::BTB_ASSOC-1:0] upd1_wen_mask;

    // ------------------------------------------------------------
    // request stage

    assign req_index = req.pc[core_types_pkg::BTB_OFFSET_WIDTH +: core_types_pkg::BTB_INDEX_WIDTH];

    btb_tag_hash req_hash (
        .pc   (req.pc),
        .asid (req.asid),
        .tag  (req_tag)
    );

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            resp_valid <= 1'b0;
            resp_tag   <= '0;
        end else begin
            resp_valid <= valid_REQ;
            if (valid_REQ) begin
                resp_tag <= req_tag;
            end
        end
    end

    // ------------------------------------------------------------
    // response stage: per slot, per way compare

    always_comb begin
        for (int s = 0; s < core_types_pkg::BTB_SLOTS; s++) begin
            for (int w = 0; w < core_types_pkg::BTB_ASSOC; w++) begin
                way_match[s][w] = (rd_entries[s][w].tag == resp_tag)
                    && (rd_entries[s][w].pred_info.kind != core_types_pkg::kind_none);
            end
            resp.hit[s] = |way_match[s];

            // way 0 wins when both match
            if (way_match[s][0]) begin
                resp.pred_info[s] = rd_entries[s][0].pred_info;
                resp.target[s]    = rd_entries[s][0].target;
                resp.pred_lru[s]  = 1'b0;
            end else if (way_match[s][1]) begin
                resp.pred_info[s] = rd_entries[s][1].pred_info;
                resp.target[s]    = rd_entries[s][1].target;
                resp.pred_lru[s]  = 1'b1;
            end else begin
                // miss: way 0 contents, stored lru suggests the fill way
                resp.pred_info[s] = rd_entries[s][0].pred_info;
                resp.target[s]    = rd_entries[s][0].target;
                resp.pred_lru[s]  = rd_lru[s];
            end
        end
    end

    // ------------------------------------------------------------
    // update 0: split address, hash with the request asid

    assign upd0_index = update0.start_pc[core_types_pkg::BTB_OFFSET_WIDTH
                                         +: core_types_pkg::BTB_INDEX_WIDTH];
    assign upd0_slot  = update0.start_pc[1 +: core_types_pkg::BTB_SLOT_WIDTH];

    btb_tag_hash upd_hash (
        .pc   (update0.start_pc),
        .asid (req.asid),
        .tag  (upd0_tag)
    );

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            upd1_valid <= 1'b0;
        end else begin
            upd1_valid <= update0_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (update0_valid) begin
            upd1_index <= upd0_index;
            upd1_slot  <= upd0_slot;
            upd1_tag   <= upd0_tag;
        end
    end

    // ------------------------------------------------------------
    // update 1: entry write and lru read-modify-write

    always_comb begin
        upd1_entry.pred_info = update1.pred_info;
        upd1_entry.tag       = upd1_tag;
        upd1_entry.target    = update1.target_pc[1 +: core_types_pkg::BTB_TARGET_WIDTH];

        // the filled way becomes most recent
        upd1_new_lru = upd1_old_lru;
        upd1_new_lru[upd1_slot] = ~update1.pred_lru;

        upd1_wen_mask = '0;
        if (upd1_valid) begin
            upd1_wen_mask[upd1_slot][update1.pred_lru] = 1'b1;
        end
    end

    bram_1rport_1wport #(
        .INNER_WIDTH (core_types_pkg::BTB_ROW_WIDTH),
        .OUTER_WIDTH (core_types_pkg::BTB_SETS)
    ) entry_ram (
        .CLK      (CLK),
        .nRST     (nRST),
        .ren      (valid_REQ),
        .rindex   (req_index),
        .rdata    (rd_entries),
        .wen_mask (upd1_wen_mask),
        .windex   (upd1_index),
        .wdata    ({(core_types_pkg::BTB_SLOTS * core_types_pkg::BTB_ASSOC){upd1_entry}})
    );

    bram_2rport_1wport #(
        .INNER_WIDTH (core_types_pkg::BTB_SLOTS),
        .OUTER_WIDTH (core_types_pkg::BTB_SETS)
    ) lru_ram (
        .CLK          (CLK),
        .nRST         (nRST),
        .port0_ren    (valid_REQ),
        .port0_rindex (req_index),
        .port0_rdata  (rd_lru),
        .port1_ren    (update0_valid),
        .port1_rindex (upd0_index),
        .port1_rdata  (upd1_old_lru),
        .wen_mask     ({core_types_pkg::BTB_SLOTS{upd1_valid}}),
        .windex       (upd1_index),
        .wdata        (upd1_new_lru)
    );

endmodule

//--- design/btb_pred_select.sv
// ------------------------------------------------------------
// picks the first taken branch at or after the fetch offset
// and forms the next fetch address from the BTB response
// ------------------------------------------------------------

`timescale 1ns/1ps

module btb_pred_select (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       valid_REQ,
    input  logic [31:0]                req_pc,
    input  core_types_pkg::btb_resp_t  resp,
    output core_types_pkg::btb_pred_t  pred
);

    logic [31:0]                          pc_q;
    logic [core_types_pkg::BTB_SLOT_WIDTH-1:0] start_slot;
    logic [core_types_pkg::BTB_SLOTS-1:0] slot_taken;
    logic [31:0]                          block_base;

    // request pc lines up with the response
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            pc_q <= '0;
        end else if (valid_REQ) begin
            pc_q <= req_pc;
        end
    end

    assign start_slot = pc_q[1 +: core_types_pkg::BTB_SLOT_WIDTH];
    assign block_base = {pc_q[31:core_types_pkg::BTB_OFFSET_WIDTH],
                         {core_types_pkg::BTB_OFFSET_WIDTH{1'b0}}};

    // per slot taken decision
    always_comb begin
        for (int s = 0; s < core_types_pkg::BTB_SLOTS; s++) begin
            case (resp.pred_info[s].kind)
                core_types_pkg::kind_jump,
                core_types_pkg::kind_ret:  slot_taken[s] = resp.hit[s];
                core_types_pkg::kind_cond: slot_taken[s] = resp.hit[s]
                                                         & resp.pred_info[s].ctr[1];
                default:                   slot_taken[s] = 1'b0;
            endcase
            // slots before the fetch offset are not executed
            if (s < start_slot) begin
                slot_taken[s] = 1'b0;
            end
        end
    end

    // priority scan, lowest slot wins
    always_comb begin
        pred.taken   = 1'b0;
        pred.slot    = '1;
        pred.next_pc = block_base + core_types_pkg::BTB_BLOCK_BYTES;
        for (int s = core_types_pkg::BTB_SLOTS - 1; s >= 0; s--) begin
            if (slot_taken[s]) begin
                pred.taken   = 1'b1;
                pred.slot    = s[core_types_pkg::BTB_SLOT_WIDTH-1:0];
                pred.next_pc = {pc_q[31:core_types_pkg::BTB_TARGET_WIDTH+1],
                                resp.target[s], 1'b0};
            end
        end
    end

endmodule

//--- design/btb_tag_hash.sv
// ------------------------------------------------------------
// folds a fetch address and ASID into the short tag kept in
// each BTB way; used on both the request and update paths
// ------------------------------------------------------------

`timescale 1ns/1ps

module btb_tag_hash (
    input  logic [31:0]                              pc,
    input  logic [core_types_pkg::ASID_WIDTH-1:0]    asid,
    output logic [core_types_pkg::BTB_TAG_WIDTH-1:0] tag
);

    // two tag-wide fields right above the set index
    logic [core_types_pkg::BTB_TAG_WIDTH-1:0] low_field;
    logic [core_types_pkg::BTB_TAG_WIDTH-1:0] high_field;

    assign low_field = pc[core_types_pkg::BTB_OFFSET_WIDTH + core_types_pkg::BTB_INDEX_WIDTH
                          +: core_types_pkg::BTB_TAG_WIDTH];
    assign high_field = pc[core_types_pkg::BTB_OFFSET_WIDTH + core_types_pkg::BTB_INDEX_WIDTH
                           + core_types_pkg::BTB_TAG_WIDTH +: core_types_pkg::BTB_TAG_WIDTH];

    // asid repeated to tag width
    assign tag = low_field ^ high_field
               ^ {(core_types_pkg::BTB_TAG_WIDTH / core_types_pkg::ASID_WIDTH){asid}};

endmodule

//--- design/core_types_pkg.sv
// ------------------------------------------------------------
// shared widths, enums and packed structs for the branch
// prediction front end; every file refers to these by
// scoped name
// ------------------------------------------------------------

package core_types_pkg;

    // fetch block geometry
    localparam int BTB_SLOTS        = 16;
    localparam int BTB_SLOT_WIDTH   = 4;
    localparam int BTB_OFFSET_WIDTH = 5;
    localparam int BTB_BLOCK_BYTES  = 32;

    // array sizing
    localparam int BTB_ASSOC        = 2;
    localparam int BTB_INDEX_WIDTH  = 6;
    localparam int BTB_SETS         = 64;
    localparam int BTB_TAG_WIDTH    = 8;
    localparam int BTB_TARGET_WIDTH = 16;
    localparam int ASID_WIDTH       = 4;

    // none marks an empty entry
    typedef enum logic [1:0] {
        kind_none = 2'd0,
        kind_cond = 2'd1,
        kind_jump = 2'd2,
        kind_ret  = 2'd3
    } branch_kind_e;

    typedef struct packed {
        branch_kind_e kind;
        logic [1:0]   ctr;
    } btb_pred_info_t;

    // one way of one slot
    typedef struct packed {
        btb_pred_info_t                pred_info;
        logic [BTB_TAG_WIDTH-1:0]      tag;
        logic [BTB_TARGET_WIDTH-1:0]   target;
    } btb_entry_t;

    localparam int BTB_ENTRY_WIDTH = $bits(btb_entry_t);
    localparam int BTB_ROW_WIDTH   = BTB_SLOTS * BTB_ASSOC * BTB_ENTRY_WIDTH;

    typedef struct packed {
        logic [31:0]           pc;
        logic [ASID_WIDTH-1:0] asid;
    } btb_req_t;

    typedef struct packed {
        logic [31:0] start_pc;
    } btb_update0_t;

    typedef struct packed {
        btb_pred_info_t pred_info;
        logic           pred_lru;
        logic [31:0]    target_pc;
    } btb_update1_t;

    typedef struct packed {
        logic [BTB_SLOTS-1:0]                         hit;
        btb_pred_info_t [BTB_SLOTS-1:0]               pred_info;
        logic [BTB_SLOTS-1:0]                         pred_lru;
        logic [BTB_SLOTS-1:0][BTB_TARGET_WIDTH-1:0]   target;
    } btb_resp_t;

    typedef struct packed {
        logic                      taken;
        logic [BTB_SLOT_WIDTH-1:0] slot;
        logic [31:0]               next_pc;
    } btb_pred_t;

endpackage

//--- verification/branch_pred_assert.sv
// ------------------------------------------------------------
// concurrent checks on the prediction front end, bound into
// the top level where both the response and prediction live
// ------------------------------------------------------------

`timescale 1ns/1ps

module branch_pred_assert (
    input logic                      CLK,
    input logic                      nRST,
    input logic                      valid_REQ,
    input logic                      resp_valid,
    input core_types_pkg::btb_resp_t resp,
    input core_types_pkg::btb_pred_t pred
);

    // assertion failures so far
    int fail_count = 0;

    // no response while held in reset
    resp_idle_in_reset: assert property (@(posedge CLK) !nRST |-> !resp_valid)
        else begin
            $error("resp_valid high while nRST is low");
            fail_count++;
        end

    // exactly one response, one cycle after each request
    resp_after_req: assert property (@(posedge CLK) disable iff (!nRST)
        valid_REQ |=> resp_valid)
        else begin
            $error("no resp_valid one cycle after valid_REQ");
            fail_count++;
        end

    no_resp_without_req: assert property (@(posedge CLK) disable iff (!nRST)
        !valid_REQ |=> !resp_valid)
        else begin
            $error("resp_valid without a request in the previous cycle");
            fail_count++;
        end

    // taken slot must be a hit
    taken_implies_hit: assert property (@(posedge CLK) disable iff (!nRST)
        (resp_valid && pred.taken) |-> resp.hit[pred.slot])
        else begin
            $error("taken prediction on a slot that did not hit");
            fail_count++;
        end

endmodule

bind branch_pred_top branch_pred_assert pred_checks (
    .CLK        (CLK),
    .nRST       (nRST),
    .valid_REQ  (valid_REQ),
    .resp_valid (resp_valid),
    .resp       (resp),
    .pred       (pred)
);

//--- verification/branch_pred_patterns.txt
# U start_pc asid kind ctr way target_pc  (kind 0 none, 1 cond, 2 jump, 3 ret)
# R pc asid exp_hit exp_pred_lru exp_taken exp_slot exp_next_pc  (all hex)
R 00001000 0 0000 0000 0 f 00001020
R fffffff0 f 0000 0000 0 f 00000000
U 00000046 1 2 0 0 00001234
R 00000040 1 0008 0000 1 3 00001234
R 00000048 1 0008 0000 0 f 00000060
R 00000040 3 0000 0008 0 f 00000060
U 0000006a 2 2 0 0 00002000
R 0000086a 2 0000 0020 0 f 00000880
U 0000086a 2 3 0 1 00004000
R 0000006a 2 0020 0000 1 5 00002000
R 0000086a 2 0020 0020 1 5 00004000
R 0000106a 2 0000 0000 0 f 00001080
U 123400a4 4 2 0 0 00005550
U 123400b2 4 1 3 0 00018888
R 123400aa 4 0204 0000 1 9 12358888
R 123400a0 4 0204 0000 1 2 12345550
R 123400b4 4 0204 0000 0 f 123400c0
U 000000e2 5 1 1 0 00000600
R 000000e0 5 0002 0000 0 f 00000100
U 000000e2 5 1 2 0 00000600
R 000000e0 5 0002 0000 1 1 00000600

//--- verification/branch_pred_tb.sv
// ------------------------------------------------------------
// testbench for the branch prediction front end; replays the
// update and request lines of the pattern file and compares
// every response with the expected values on the same line
// ------------------------------------------------------------

`timescale 1ns/1ps

module branch_pred_tb;

    localparam int RESP_TIMEOUT = 20;
    localparam int MAX_LINES    = 1000;

    logic                          CLK;
    logic                          nRST;
    logic                          valid_REQ;
    core_types_pkg::btb_req_t      req;
    logic                          update0_valid;
    core_types_pkg::btb_update0_t  update0;
    core_types_pkg::btb_update1_t  update1;
    logic                          resp_valid;
    core_types_pkg::btb_resp_t     resp;
    core_types_pkg::btb_pred_t     pred;

    int fd;
    int tests;
    int failed;
    bit aborted;

    branch_pred_top dut (
        .CLK           (CLK),
        .nRST          (nRST),
        .valid_REQ     (valid_REQ),
        .req           (req),
        .update0_valid (update0_valid),
        .update0       (update0),
        .update1       (update1),
        .resp_valid    (resp_valid),
        .resp          (resp),
        .pred          (pred)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // ------------------------------------------------------------
    // update 0, then update 1, then one idle cycle
    // update hash uses the request asid, so it is driven too
    task automatic apply_update(input logic [31:0] start_pc, input logic [3:0] asid,
                                input logic [1:0] kind, input logic [1:0] ctr,
                                input logic way, input logic [31:0] target_pc);
        @(posedge CLK);
        update0_valid    <= 1'b1;
        update0.start_pc <= start_pc;
        req.asid         <= asid;
        @(posedge CLK);
        update0_valid          <= 1'b0;
        update1.pred_info.kind <= core_types_pkg::branch_kind_e'(kind);
        update1.pred_info.ctr  <= ctr;
        update1.pred_lru       <= way;
        update1.target_pc      <= target_pc;
        @(posedge CLK);
    endtask

    // ------------------------------------------------------------
    // one request, wait for the response, compare all fields
    task automatic run_request(input logic [31:0] pc, input logic [3:0] asid,
                               input logic [15:0] exp_hit, input logic [15:0] exp_lru,
                               input logic exp_taken, input logic [3:0] exp_slot,
                               input logic [31:0] exp_next);
        int wait_cycles;
        int errs;
        wait_cycles = 0;
        errs        = 0;
        @(posedge CLK);
        valid_REQ <= 1'b1;
        req.pc    <= pc;
        req.asid  <= asid;
        @(posedge CLK);
        valid_REQ <= 1'b0;
        // sample on the falling edge, away from the drive edge
        @(negedge CLK);
        while (!resp_valid && wait_cycles < RESP_TIMEOUT) begin
            @(negedge CLK);
            wait_cycles++;
        end
        if (!resp_valid) begin
            $display("timeout: no response within %0d cycles to the request at pc %h",
                     RESP_TIMEOUT, pc);
            aborted = 1'b1;
        end else begin
            assert (resp.hit == exp_hit) else begin
                $display("Fail %0t: hit vector %h, expected %h", $time, resp.hit, exp_hit);
                errs++;
            end
            assert (resp.pred_lru == exp_lru) else begin
                $display("Fail %0t: pred_lru vector %h, expected %h",
                         $time, resp.pred_lru, exp_lru);
                errs++;
            end
            assert (pred.taken == exp_taken) else begin
                $display("Fail %0t: taken %b, expected %b", $time, pred.taken, exp_taken);
                errs++;
            end
            assert (pred.slot == exp_slot) else begin
                $display("Fail %0t: slot %0d, expected %0d", $time, pred.slot, exp_slot);
                errs++;
            end
            assert (pred.next_pc == exp_next) else begin
                $display("Fail %0t: next_pc %h, expected %h", $time, pred.next_pc, exp_next);
                errs++;
            end
            tests++;
            if (errs != 0) begin
                failed++;
                $display("test %0d pc %h asid %0d: %0d mismatches", tests, pc, asid, errs);
            end else begin
                $display("test %0d pc %h asid %0d: ok", tests, pc, asid);
            end
        end
    endtask

    // ------------------------------------------------------------
    // line types are # comment, U update and R request
    task automatic run_patterns();
        logic [63:0]      word;
        logic [8*160-1:0] rest;
        logic [31:0]      pc;
        logic [31:0]      target_pc;
        logic [31:0]      exp_next;
        logic [3:0]       asid;
        logic [3:0]       exp_slot;
        logic [1:0]       kind;
        logic [1:0]       ctr;
        logic             way;
        logic             exp_taken;
        logic [15:0]      exp_hit;
        logic [15:0]      exp_lru;
        int               code;
        int               lines;
        lines = 0;
        while (!aborted && lines < MAX_LINES) begin
            code = $fscanf(fd, "%s", word);
            if (code != 1) begin
                break;
            end
            lines++;
            if (word == "#") begin
                code = $fgets(rest, fd);
            end else if (word == "U") begin
                code = $fscanf(fd, "%h %h %h %h %h %h", pc, asid, kind, ctr, way, target_pc);
                if (code != 6) begin
                    $display("malformed update line %0d in the pattern file", lines);
                    aborted = 1'b1;
                end else begin
                    apply_update(pc, asid, kind, ctr, way, target_pc);
                end
            end else if (word == "R") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h", pc, asid, exp_hit, exp_lru,
                               exp_taken, exp_slot, exp_next);
                if (code != 7) begin
                    $display("malformed request line %0d in the pattern file", lines);
                    aborted = 1'b1;
                end else begin
                    run_request(pc, asid, exp_hit, exp_lru, exp_taken, exp_slot, exp_next);
                end
            end else begin
                $display("unknown line type on line %0d of the pattern file", lines);
                aborted = 1'b1;
            end
        end
    endtask

    initial begin
        nRST          = 1'b0;
        valid_REQ     = 1'b0;
        req           = '0;
        update0_valid = 1'b0;
        update0       = '0;
        update1       = '0;
        tests         = 0;
        failed        = 0;
        aborted       = 1'b0;

        repeat (10) @(posedge CLK);
        nRST <= 1'b1;

        fd = $fopen("verification/branch_pred_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/branch_pred_patterns.txt");
            aborted = 1'b1;
        end else begin
            run_patterns();
            $fclose(fd);
        end

        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 tests, tests - failed, failed, dut.pred_checks.fail_count);
        if (aborted || tests == 0 || failed != 0 || dut.pred_checks.fail_count != 0) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule
